// ==== include/programImage.svh ====
`ifndef PROGRAM_IMAGE_SVH
`define PROGRAM_IMAGE_SVH
// I-type ALU group {imm[11:0], rs1, funct3, rd, opcode}
mem[0] = {12'h2BC, 5'd0, 3'b000, 5'd1, rv32Pkg::OPC_ITYPE};   // ADDI x1 = x0 + 0x2BC
mem[1] = {12'd24, 5'd1, 3'b001, 5'd2, rv32Pkg::OPC_ITYPE};    // SLLI x2 = x1 << 24
mem[2] = {12'd0, 5'd2, 3'b010, 5'd3, rv32Pkg::OPC_ITYPE};     // SLTI x3 = x2 < 0
mem[3] = {12'd0, 5'd2, 3'b011, 5'd4, rv32Pkg::OPC_ITYPE};     // SLTIU x4 = x2 < 0 unsigned
mem[4] = {12'h653, 5'd1, 3'b100, 5'd5, rv32Pkg::OPC_ITYPE};   // XORI x5 = x1 ^ 0x653
mem[5] = {7'b0000000, 5'd4, 5'd2, 3'b101, 5'd6, rv32Pkg::OPC_ITYPE}; // SRLI x6 = x2 >> 4
mem[6] = {7'b0100000, 5'd4, 5'd2, 3'b101, 5'd7, rv32Pkg::OPC_ITYPE}; // SRAI x7 = x2 >>> 4
mem[7] = {12'h0BC, 5'd2, 3'b110, 5'd8, rv32Pkg::OPC_ITYPE};   // ORI x8 = x2 | 0xBC
mem[8] = {12'h0EC, 5'd5, 3'b111, 5'd9, rv32Pkg::OPC_ITYPE};   // ANDI x9 = x5 & 0xEC
// R-type group {funct7, rs2, rs1, funct3, rd, opcode}
mem[9] = {7'b0000000, 5'd9, 5'd1, 3'b000, 5'd10, rv32Pkg::OPC_RTYPE};   // ADD x10 = x1 + x9
mem[10] = {7'b0100000, 5'd5, 5'd6, 3'b000, 5'd11, rv32Pkg::OPC_RTYPE};  // SUB x11 = x6 - x5
mem[11] = {7'b0000000, 5'd3, 5'd7, 3'b001, 5'd12, rv32Pkg::OPC_RTYPE};  // SLL x12 = x7 << x3
mem[12] = {7'b0000000, 5'd2, 5'd1, 3'b010, 5'd13, rv32Pkg::OPC_RTYPE};  // SLT x13
mem[13] = {7'b0000000, 5'd2, 5'd1, 3'b011, 5'd14, rv32Pkg::OPC_RTYPE};  // SLTU x14
mem[14] = {7'b0000000, 5'd8, 5'd12, 3'b100, 5'd15, rv32Pkg::OPC_RTYPE}; // XOR x15 = x12 ^ x8
mem[15] = {7'b0000000, 5'd3, 5'd12, 3'b101, 5'd16, rv32Pkg::OPC_RTYPE}; // SRL x16
mem[16] = {7'b0100000, 5'd3, 5'd12, 3'b101, 5'd17, rv32Pkg::OPC_RTYPE}; // SRA x17
mem[17] = {7'b0000000, 5'd7, 5'd11, 3'b110, 5'd18, rv32Pkg::OPC_RTYPE}; // OR x18 = x11 | x7
mem[18] = {7'b0000000, 5'd11, 5'd7, 3'b111, 5'd19, rv32Pkg::OPC_RTYPE}; // AND x19 = x7 & x11
// Stores {imm[11:5], rs2, rs1, funct3, imm[4:0], opcode}
mem[19] = {7'd0, 5'd11, 5'd1, 3'b010, 5'd4, rv32Pkg::OPC_STORE};  // SW x11 to x1 + 4
mem[20] = {7'd0, 5'd10, 5'd1, 3'b001, 5'd7, rv32Pkg::OPC_STORE};  // SH x10 to x1 + 7, misaligned data
mem[21] = {7'd0, 5'd15, 5'd1, 3'b000, 5'd4, rv32Pkg::OPC_STORE};  // SB x15 to x1 + 4
// Loads share the I layout
mem[22] = {12'd5, 5'd1, 3'b010, 5'd20, rv32Pkg::OPC_LOAD};        // LW x20 from x1 + 5
mem[23] = {12'd4, 5'd1, 3'b001, 5'd21, rv32Pkg::OPC_LOAD};        // LH x21
mem[24] = {12'd4, 5'd1, 3'b000, 5'd22, rv32Pkg::OPC_LOAD};        // LB x22
mem[25] = {12'd4, 5'd1, 3'b101, 5'd23, rv32Pkg::OPC_LOAD};        // LHU x23
mem[26] = {12'd4, 5'd1, 3'b100, 5'd24, rv32Pkg::OPC_LOAD};        // LBU x24
mem[27] = {20'd1, 5'd25, rv32Pkg::OPC_LUI};                       // LUI x25 = 0x1000
mem[28] = {20'd1, 5'd26, rv32Pkg::OPC_AUIPC};                     // AUIPC x26 = pc + 0x1000
mem[29] = {20'b0_0000001111_0_00000000, 5'd27, rv32Pkg::OPC_JAL}; // JAL x27, offset 0x1E
// Branches {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], opcode}
mem[30] = {1'b0, 6'd0, 5'd2, 5'd1, 3'b000, 4'b0100, 1'b0, rv32Pkg::OPC_BRANCH};  // BEQ +8
mem[31] = {1'b0, 6'd0, 5'd13, 5'd0, 3'b001, 4'b0100, 1'b0, rv32Pkg::OPC_BRANCH}; // BNE +8
mem[32] = {1'b0, 6'd0, 5'd2, 5'd1, 3'b100, 4'b0100, 1'b0, rv32Pkg::OPC_BRANCH};  // BLT +8
mem[33] = {1'b0, 6'd0, 5'd1, 5'd2, 3'b101, 4'b0100, 1'b0, rv32Pkg::OPC_BRANCH};  // BGE +8
mem[34] = {1'b0, 6'd0, 5'd1, 5'd2, 3'b110, 4'b0100, 1'b0, rv32Pkg::OPC_BRANCH};  // BLTU +8
mem[35] = {1'b0, 6'd0, 5'd1, 5'd2, 3'b111, 4'b0100, 1'b0, rv32Pkg::OPC_BRANCH};  // BGEU +8
mem[36] = {12'd0, 5'd27, 3'b000, 5'd28, rv32Pkg::OPC_JALR};       // JALR x28, back to x27
mem[43] = {12'h2BC, 5'd0, 3'b000, 5'd0, rv32Pkg::OPC_ITYPE};      // Hint, write to x0 is dropped
mem[44] = {12'd0, 5'd0, 3'b000, 5'd0, rv32Pkg::OPC_SYSTEM};       // ECALL
mem[45] = {12'd1, 5'd27, 3'b000, 5'd28, rv32Pkg::OPC_JALR};       // JALR to x27 + 1, misaligned
mem[46] = {7'd0, 5'd5, 5'd1, 3'b001, 5'd1, rv32Pkg::OPC_STORE};   // SH x5 to x1 + 1
mem[47] = {20'hFFFFF, 5'd22, rv32Pkg::OPC_LUI};                   // LUI x22 = 0xFFFFF000
mem[48] = {12'hFBC, 5'd22, 3'b000, 5'd22, rv32Pkg::OPC_ITYPE};    // ADDI x22 += -0x44
mem[49] = {20'hABADC, 5'd23, rv32Pkg::OPC_LUI};                   // LUI x23 = 0xABADC000
mem[50] = {12'hB02, 5'd23, 3'b000, 5'd23, rv32Pkg::OPC_ITYPE};    // ADDI x23 += -0x4FE
mem[51] = {12'd1, 5'd0, 3'b000, 5'd0, rv32Pkg::OPC_SYSTEM};       // EBREAK
mem[52] = {12'h2BC, 5'd0, 3'b000, 5'd0, rv32Pkg::OPC_ITYPE};      // Hint as a pipeline filler
// Handler at TRAP_VECTOR, sorts ECALL from faults by mcause
mem[1024] = {12'h342, 5'd0, 3'b010, 5'd6, rv32Pkg::OPC_SYSTEM};   // CSRRS x6 = mcause
mem[1025] = {12'd11, 5'd0, 3'b000, 5'd7, rv32Pkg::OPC_ITYPE};     // ADDI x7 = 11, ECALL cause
mem[1026] = {1'b0, 6'd0, 5'd7, 5'd6, 3'b000, 4'b0110, 1'b0, rv32Pkg::OPC_BRANCH}; // BEQ +12
mem[1027] = {12'hFF, 5'd2, 3'b000, 5'd30, rv32Pkg::OPC_ITYPE};    // ADDI x30 = x2 + 0xFF
mem[1028] = {1'b0, 10'b0000000100, 1'b0, 8'd0, 5'd0, rv32Pkg::OPC_JAL}; // JAL x0, +8
mem[1029] = {12'd0, 5'd0, 3'b000, 5'd1, rv32Pkg::OPC_ITYPE};      // ADDI x1 = 0 on ECALL
mem[1030] = {12'h302, 5'd0, 3'b000, 5'd0, rv32Pkg::OPC_SYSTEM};   // MRET
mem[1031] = {12'h2BC, 5'd0, 3'b000, 5'd0, rv32Pkg::OPC_ITYPE};    // Filler after MRET
`endif

// ==== hdl/rv32Pkg.sv ====
package rv32Pkg;

	localparam int WORD_BITS = 32;                              // RV32 data and address width
	localparam int REG_IDX_BITS = 5;                            // 32 integer registers
	localparam int OPCODE_BITS = 7;                             // Major opcode field width
	localparam int IMEM_WORDS = 2048;                           // ROM depth in words
	localparam int IMEM_ADDR_BITS = $clog2(IMEM_WORDS);         // Word address taken from pc[12:2]

	typedef logic [WORD_BITS-1:0] word_t;                       // Instruction, address or immediate
	typedef logic [REG_IDX_BITS-1:0] regIdx_t;                  // rd, rs1 or rs2
	typedef logic [OPCODE_BITS-1:0] opcode_t;                   // instruction[6:0]
	typedef logic [IMEM_ADDR_BITS-1:0] imemAddr_t;              // Wraps every 8 KiB of pc

	localparam word_t RESET_PC = 32'h0000_0000;                 // First fetch after reset
	localparam word_t TRAP_VECTOR = 32'h0000_1000;              // ROM word 1024, handler entry

	// RV32I major opcodes, low two bits always 11
	localparam opcode_t OPC_LOAD = 7'b000_0011;                 // LB LH LW LBU LHU
	localparam opcode_t OPC_ITYPE = 7'b001_0011;                // ALU with immediate
	localparam opcode_t OPC_AUIPC = 7'b001_0111;                // pc relative upper immediate
	localparam opcode_t OPC_STORE = 7'b010_0011;                // SB SH SW
	localparam opcode_t OPC_RTYPE = 7'b011_0011;                // Register to register ALU
	localparam opcode_t OPC_LUI = 7'b011_0111;                  // Load upper immediate
	localparam opcode_t OPC_BRANCH = 7'b110_0011;               // Conditional branches
	localparam opcode_t OPC_JALR = 7'b110_0111;                 // Indirect jump, I format
	localparam opcode_t OPC_JAL = 7'b110_1111;                  // Direct jump, J format
	localparam opcode_t OPC_SYSTEM = 7'b111_0011;               // ECALL EBREAK MRET and CSR ops

	typedef enum logic [2:0] {
		FMT_R,                                                  // No immediate
		FMT_I,                                                  // imm[11:0] in bits 31:20
		FMT_S,                                                  // Split store offset
		FMT_B,                                                  // Split branch offset, even
		FMT_U,                                                  // Upper 20 bits
		FMT_J,                                                  // Jump offset, even
		FMT_ILLEGAL                                             // Opcode not in RV32I base set
	} instrFormat_t;

	// One decoded instruction as it leaves the decode register
	typedef struct packed {
		word_t pc;                                              // Fetch address of this word
		word_t raw;                                             // Undecoded instruction bits
		instrFormat_t format;                                   // Encoding class
		opcode_t opcode;                                        // Major opcode
		regIdx_t rd;                                            // Destination register
		regIdx_t rs1;                                           // First source register
		regIdx_t rs2;                                           // Second source register
		logic [2:0] funct3;                                     // Minor operation select
		logic [6:0] funct7;                                     // ADD/SUB and SRL/SRA select
		word_t imm;                                             // Sign-extended immediate
		logic fetchMisaligned;                                  // Fetched at trap vector after a bad redirect
	} decodedInstr_t;

endpackage

// ==== hdl/programCounter.sv ====
module programCounter (
	input  logic clk,
	input  logic rstN,
	input  logic stall,                                         // Freezes pc and the fault flag
	input  logic redirectValid,                                 // One-cycle jump request
	input  rv32Pkg::word_t redirectTarget,
	output rv32Pkg::word_t pc,
	output logic fetchMisaligned                                // Current fetch came from a bad redirect
);

	logic targetMisaligned;                                     // Target is not on a word boundary
	rv32Pkg::word_t nextPc;
	logic nextMisaligned;

	assign targetMisaligned = |redirectTarget[1:0];             // Only 4-byte aligned targets are legal

	// Trap takes priority over a normal redirect, which beats the increment
	always_comb begin
		nextPc = pc + 32'd4;                                    // Default sequential step
		nextMisaligned = 1'b0;                                  // Flag lives for one fetch only
		if (redirectValid && targetMisaligned) begin
			nextPc = rv32Pkg::TRAP_VECTOR;                      // Divert to the handler
			nextMisaligned = 1'b1;                              // Tag the handler's first fetch
		end else if (redirectValid) begin
			nextPc = redirectTarget;                            // Aligned jump is taken as is
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= rv32Pkg::RESET_PC;
			fetchMisaligned <= 1'b0;
		end else if (!stall) begin                              // A redirect during stall is lost
			pc <= nextPc;
			fetchMisaligned <= nextMisaligned;
		end
	end

endmodule

// ==== hdl/instructionMemory.sv ====
module instructionMemory (
	input  rv32Pkg::word_t pc,                                  // Byte address of the fetch
	output rv32Pkg::word_t instruction                          // Word at that address, same cycle
);

	rv32Pkg::word_t mem [rv32Pkg::IMEM_WORDS];                  // Program ROM
	rv32Pkg::imemAddr_t wordAddr;                               // pc[12:2], upper bits ignored

	initial begin
		for (int i = 0; i < rv32Pkg::IMEM_WORDS; i++) begin
			mem[i] = '0;                                        // Unused words decode as illegal
		end
		`include "programImage.svh"
	end

	assign wordAddr = pc[rv32Pkg::IMEM_ADDR_BITS+1:2];          // Drop the byte offset

	always_comb begin
		instruction = mem[wordAddr];                            // Asynchronous read
	end

endmodule

// ==== hdl/immediateGenerator.sv ====
module immediateGenerator (
	input  rv32Pkg::word_t instruction,
	input  rv32Pkg::instrFormat_t format,                       // Selects which bits form the immediate
	output rv32Pkg::word_t imm                                  // Sign-extended from instruction[31]
);

	logic signBit;

	assign signBit = instruction[31];                           // Every RV32I immediate keeps its sign here

	always_comb begin
		case (format)
			rv32Pkg::FMT_I: begin
				imm = {{20{signBit}}, instruction[31:20]};      // imm[11:0] in one piece
			end
			rv32Pkg::FMT_S: begin
				imm = {{20{signBit}}, instruction[31:25], instruction[11:7]}; // Split around rs2 and rs1
			end
			rv32Pkg::FMT_B: begin
				imm = {{19{signBit}}, instruction[31], instruction[7],
					instruction[30:25], instruction[11:8], 1'b0};   // Bit 11 sits in bit 7, offset is even
			end
			rv32Pkg::FMT_U: begin
				imm = {instruction[31:12], 12'h000};            // Upper field, low bits zero
			end
			rv32Pkg::FMT_J: begin
				imm = {{11{signBit}}, instruction[31], instruction[19:12],
					instruction[20], instruction[30:21], 1'b0};     // Scrambled 20-bit jump offset
			end
			default: begin
				imm = '0;                                       // R type and illegal words carry none
			end
		endcase
	end

endmodule

// ==== hdl/instructionDecoder.sv ====
module instructionDecoder (
	input  logic clk,
	input  logic rstN,
	input  logic stall,                                         // Holds the output register
	input  logic redirectValid,                                 // Marks the word now in decode as wrong path
	input  rv32Pkg::word_t pc,
	input  rv32Pkg::word_t instruction,
	input  logic fetchMisaligned,
	output rv32Pkg::decodedInstr_t decoded,
	output logic decodedValid
);

	rv32Pkg::opcode_t opcode;
	rv32Pkg::instrFormat_t format;
	rv32Pkg::word_t imm;
	rv32Pkg::decodedInstr_t decodeNext;                         // Combinational result for this pc

	assign opcode = instruction[6:0];

	// Map the major opcode to its encoding class
	always_comb begin
		case (opcode)
			rv32Pkg::OPC_RTYPE: format = rv32Pkg::FMT_R;
			rv32Pkg::OPC_LOAD,
			rv32Pkg::OPC_ITYPE,
			rv32Pkg::OPC_JALR,
			rv32Pkg::OPC_SYSTEM: format = rv32Pkg::FMT_I;       // All use imm[11:0] in bits 31:20
			rv32Pkg::OPC_STORE: format = rv32Pkg::FMT_S;
			rv32Pkg::OPC_BRANCH: format = rv32Pkg::FMT_B;
			rv32Pkg::OPC_LUI,
			rv32Pkg::OPC_AUIPC: format = rv32Pkg::FMT_U;
			rv32Pkg::OPC_JAL: format = rv32Pkg::FMT_J;
			default: format = rv32Pkg::FMT_ILLEGAL;             // Includes all-zero ROM words
		endcase
	end

	immediateGenerator immediateGeneratorInst (
		.instruction(instruction),
		.format(format),
		.imm(imm)
	);

	// Field slices are fixed in RV32I, so no format gating is needed
	always_comb begin
		decodeNext.pc = pc;
		decodeNext.raw = instruction;
		decodeNext.format = format;
		decodeNext.opcode = opcode;
		decodeNext.rd = instruction[11:7];
		decodeNext.rs1 = instruction[19:15];
		decodeNext.rs2 = instruction[24:20];
		decodeNext.funct3 = instruction[14:12];
		decodeNext.funct7 = instruction[31:25];
		decodeNext.imm = imm;
		decodeNext.fetchMisaligned = fetchMisaligned;           // Travels with the trap-vector fetch
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			decoded <= '0;
			decodedValid <= 1'b0;                               // Nothing fetched yet
		end else if (!stall) begin
			decoded <= decodeNext;
			decodedValid <= !redirectValid;                     // Flush the wrong-path word on a redirect
		end
	end

endmodule

// ==== hdl/fetchDecodeStage.sv ====
module fetchDecodeStage (
	input  logic clk,
	input  logic rstN,
	input  logic stall,                                         // Level, freezes the front end
	input  logic redirectValid,                                 // Strobe, repeat it if stall was high
	input  rv32Pkg::word_t redirectTarget,
	output rv32Pkg::word_t fetchPc,                             // Address being fetched this cycle
	output rv32Pkg::decodedInstr_t decoded,                     // Lags fetchPc by one clock
	output logic decodedValid
);

	rv32Pkg::word_t pc;                                         // Fetch address from the counter
	rv32Pkg::word_t instruction;                                // ROM word at pc
	logic fetchMisaligned;                                      // Set on the fetch after a bad redirect

	programCounter programCounterInst (
		.clk(clk),
		.rstN(rstN),
		.stall(stall),
		.redirectValid(redirectValid),
		.redirectTarget(redirectTarget),
		.pc(pc),
		.fetchMisaligned(fetchMisaligned)
	);

	instructionMemory instructionMemoryInst (
		.pc(pc),
		.instruction(instruction)
	);

	instructionDecoder instructionDecoderInst (
		.clk(clk),
		.rstN(rstN),
		.stall(stall),
		.redirectValid(redirectValid),
		.pc(pc),
		.instruction(instruction),
		.fetchMisaligned(fetchMisaligned),
		.decoded(decoded),
		.decodedValid(decodedValid)
	);

	assign fetchPc = pc;                                        // Exposed for the execute side

endmodule

// ==== bench/fetchDecodeStage_sva.sv ====
module fetchDecodeStageSva (
	input logic clk,
	input logic rstN,
	input logic stall,                                          // Level that freezes the front end
	input logic redirectValid,                                  // Jump strobe from outside
	input rv32Pkg::word_t fetchPc,                              // Current fetch address
	input logic decodedValid                                    // Decode register holds a real instruction
);
	timeunit 1ns;
	timeprecision 100ps;

	// A stalled edge must leave the fetch address where it was
	stallHoldsPc: assert property (@(posedge clk) disable iff (!rstN)
		stall |=> $stable(fetchPc))
		else $error("fetchPc changed on an edge where stall was high");

	// The wrong-path word in decode is dropped after an accepted redirect
	redirectFlushes: assert property (@(posedge clk) disable iff (!rstN)
		(redirectValid && !stall) |=> !decodedValid)
		else $error("decodedValid stayed high in the cycle after a redirect");

	// Misaligned targets are diverted, so the pc never leaves a word boundary
	pcAligned: assert property (@(posedge clk) disable iff (!rstN)
		fetchPc[1:0] == 2'b00)
		else $error("fetchPc has nonzero low bits");

endmodule

bind fetchDecodeStage fetchDecodeStageSva fetchDecodeStageSvaInst (
	.clk(clk),
	.rstN(rstN),
	.stall(stall),
	.redirectValid(redirectValid),
	.fetchPc(fetchPc),
	.decodedValid(decodedValid)
);

// ==== bench/fetchDecodeStageTb.sv ====
module fetchDecodeStageTb;
	timeunit 1ns;
	timeprecision 100ps;

	// One table row, inputs for this cycle and the outputs seen before its edge
	typedef struct packed {
		logic stall;
		logic redirectValid;
		rv32Pkg::word_t redirectTarget;
		logic expValid;                                         // Expected decodedValid
		rv32Pkg::word_t expFetchPc;
		rv32Pkg::word_t expPc;                                  // Expected decoded.pc
		rv32Pkg::instrFormat_t expFormat;
		rv32Pkg::regIdx_t expRd;
		rv32Pkg::regIdx_t expRs1;
		rv32Pkg::word_t expImm;
		logic expMisaligned;
	} stimRow_t;

	logic clk;
	logic rstN;
	logic stall;
	logic redirectValid;
	rv32Pkg::word_t redirectTarget;
	rv32Pkg::word_t fetchPc;
	rv32Pkg::decodedInstr_t decoded;
	logic decodedValid;

	stimRow_t rows [$];                                         // Stimulus table, filled at time zero
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int cycleLimit = 0;                                         // Zero until the table length is known

	fetchDecodeStage fetchDecodeStage_inst (
		.clk(clk),
		.rstN(rstN),
		.stall(stall),
		.redirectValid(redirectValid),
		.redirectTarget(redirectTarget),
		.fetchPc(fetchPc),
		.decoded(decoded),
		.decodedValid(decodedValid)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;                                 // 20 ns period
	end

	// Watchdog so a stuck run still ends
	always @(posedge clk) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount > cycleLimit) begin
			$display("Run timed out after %0d cycles before the table finished", cycleCount);
			$display("Errors: %0d of %0d checks", errorCount, checkCount);
			$display("Checks failed");
			$finish;
		end
	end

	task automatic addRow(input logic st, input logic rv, input rv32Pkg::word_t tgt,
		input logic v, input rv32Pkg::word_t fpc, input rv32Pkg::word_t dpc,
		input rv32Pkg::instrFormat_t fmt, input rv32Pkg::regIdx_t rd,
		input rv32Pkg::regIdx_t rs1, input rv32Pkg::word_t imm, input logic mis);
		rows.push_back('{st, rv, tgt, v, fpc, dpc, fmt, rd, rs1, imm, mis});
	endtask

	task automatic checkField(input string name, input int idx, input rv32Pkg::word_t got,
		input rv32Pkg::word_t expected);
		checkCount++;
		assert (got === expected) else begin
			errorCount++;
			$display("[FAIL] %0d ns row %0d %s got 0x%08h expected 0x%08h",
				$time, idx, name, got, expected);
		end
	endtask

	// Decoded fields only mean something while decodedValid is high
	task automatic checkRow(input int idx, input stimRow_t r);
		checkField("fetchPc", idx, fetchPc, r.expFetchPc);
		checkField("decodedValid", idx, 32'(decodedValid), 32'(r.expValid));
		if (r.expValid) begin
			checkField("decoded.pc", idx, decoded.pc, r.expPc);
			checkField("decoded.format", idx, 32'(decoded.format), 32'(r.expFormat));
			checkField("decoded.rd", idx, 32'(decoded.rd), 32'(r.expRd));
			checkField("decoded.rs1", idx, 32'(decoded.rs1), 32'(r.expRs1));
			checkField("decoded.imm", idx, decoded.imm, r.expImm);
			checkField("decoded.fetchMisaligned", idx, 32'(decoded.fetchMisaligned),
				32'(r.expMisaligned));
		end
	endtask

	task automatic loadTable();
		addRow(0, 0, 'h000, 0, 'h000, 'h000, rv32Pkg::FMT_R, 0, 0, 'h000, 0);      // Reset just released
		addRow(0, 0, 'h000, 1, 'h004, 'h000, rv32Pkg::FMT_I, 1, 0, 'h2BC, 0);      // ADDI x1
		addRow(0, 0, 'h000, 1, 'h008, 'h004, rv32Pkg::FMT_I, 2, 1, 'h018, 0);      // SLLI
		addRow(0, 0, 'h000, 1, 'h00C, 'h008, rv32Pkg::FMT_I, 3, 2, 'h000, 0);      // SLTI
		addRow(0, 0, 'h000, 1, 'h010, 'h00C, rv32Pkg::FMT_I, 4, 2, 'h000, 0);      // SLTIU
		addRow(0, 0, 'h000, 1, 'h014, 'h010, rv32Pkg::FMT_I, 5, 1, 'h653, 0);      // XORI
		addRow(0, 0, 'h000, 1, 'h018, 'h014, rv32Pkg::FMT_I, 6, 2, 'h004, 0);      // SRLI
		addRow(0, 1, 'h024, 1, 'h01C, 'h018, rv32Pkg::FMT_I, 7, 2, 'h404, 0);      // SRAI, jump to ADD
		addRow(0, 0, 'h000, 0, 'h024, 'h000, rv32Pkg::FMT_R, 0, 0, 'h000, 0);      // Flushed slot
		addRow(0, 1, 'h04C, 1, 'h028, 'h024, rv32Pkg::FMT_R, 10, 1, 'h000, 0);     // ADD, jump to SW
		addRow(0, 0, 'h000, 0, 'h04C, 'h000, rv32Pkg::FMT_R, 0, 0, 'h000, 0);
		addRow(0, 0, 'h000, 1, 'h050, 'h04C, rv32Pkg::FMT_S, 4, 1, 'h004, 0);      // SW offset 4
		addRow(0, 0, 'h000, 1, 'h054, 'h050, rv32Pkg::FMT_S, 7, 1, 'h007, 0);      // SH
		addRow(0, 0, 'h000, 1, 'h058, 'h054, rv32Pkg::FMT_S, 4, 1, 'h004, 0);      // SB
		addRow(0, 1, 'h078, 1, 'h05C, 'h058, rv32Pkg::FMT_I, 20, 1, 'h005, 0);     // LW, jump to word 30
		addRow(0, 0, 'h000, 0, 'h078, 'h000, rv32Pkg::FMT_R, 0, 0, 'h000, 0);
		addRow(0, 0, 'h000, 1, 'h07C, 'h078, rv32Pkg::FMT_B, 8, 1, 'h008, 0);      // BEQ +8
		addRow(0, 1, 'h06C, 1, 'h080, 'h07C, rv32Pkg::FMT_B, 8, 0, 'h008, 0);      // BNE, jump to LUI
		addRow(0, 0, 'h000, 0, 'h06C, 'h000, rv32Pkg::FMT_R, 0, 0, 'h000, 0);
		addRow(0, 0, 'h000, 1, 'h070, 'h06C, rv32Pkg::FMT_U, 25, 0, 'h1000, 0);    // LUI
		addRow(0, 0, 'h000, 1, 'h074, 'h070, rv32Pkg::FMT_U, 26, 0, 'h1000, 0);    // AUIPC
		addRow(0, 1, 'h079, 1, 'h078, 'h074, rv32Pkg::FMT_J, 27, 0, 'h01E, 0);     // JAL, bad redirect
		addRow(0, 0, 'h000, 0, 'h1000, 'h000, rv32Pkg::FMT_R, 0, 0, 'h000, 0);     // Trap vector fetch
		addRow(0, 0, 'h000, 1, 'h1004, 'h1000, rv32Pkg::FMT_I, 6, 0, 'h342, 1);    // CSRRS, flagged
		addRow(0, 1, 'h0C0, 1, 'h1008, 'h1004, rv32Pkg::FMT_I, 7, 0, 'h00B, 0);    // Flag gone
		addRow(0, 0, 'h000, 0, 'h0C0, 'h000, rv32Pkg::FMT_R, 0, 0, 'h000, 0);
		addRow(0, 0, 'h000, 1, 'h0C4, 'h0C0, rv32Pkg::FMT_I, 22, 22, 'hFFFF_FFBC, 0); // Negative
		addRow(0, 1, 'h0F0, 1, 'h0C8, 'h0C4, rv32Pkg::FMT_U, 23, 27, 'hABAD_C000, 0); // To word 60
		addRow(0, 0, 'h000, 0, 'h0F0, 'h000, rv32Pkg::FMT_R, 0, 0, 'h000, 0);
		addRow(1, 1, 'h000, 1, 'h0F4, 'h0F0, rv32Pkg::FMT_ILLEGAL, 0, 0, 'h000, 0); // Stall drops jump
		addRow(0, 0, 'h000, 1, 'h0F4, 'h0F0, rv32Pkg::FMT_ILLEGAL, 0, 0, 'h000, 0); // Still held
		addRow(0, 0, 'h000, 1, 'h0F8, 'h0F4, rv32Pkg::FMT_ILLEGAL, 0, 0, 'h000, 0); // Stepping again
	endtask

	initial begin
		int repeats;
		void'($urandom(32'h02d9_db73));                         // Seeds the generator for stall lengths
		rstN = 1'b0;
		stall = 1'b0;
		redirectValid = 1'b0;
		redirectTarget = '0;
		loadTable();
		cycleLimit = rows.size() + 8 + 50;                      // Table, reset and some slack
		repeat (8) @(posedge clk);
		#2;
		checkCount++;
		assert (decoded === '0 && decodedValid === 1'b0 && fetchPc === rv32Pkg::RESET_PC)
		else begin
			errorCount++;
			$display("[FAIL] %0d ns reset state wrong, decode register or pc not cleared", $time);
		end
		rstN = 1'b1;
		for (int i = 0; i < rows.size(); i++) begin
			repeats = rows[i].stall ? 1 + ($urandom % 4) : 1;   // Stall rows last 1 to 4 cycles
			for (int k = 0; k < repeats; k++) begin
				stall = rows[i].stall;
				redirectValid = rows[i].redirectValid;
				redirectTarget = rows[i].redirectTarget;
				#16;                                            // Sample 2 ns before the next edge
				checkRow(i, rows[i]);
				@(posedge clk);
				#2;
			end
		end
		$display("Errors: %0d of %0d checks", errorCount, checkCount);
		if (errorCount == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+include
hdl/rv32Pkg.sv
hdl/programCounter.sv
hdl/instructionMemory.sv
hdl/immediateGenerator.sv
hdl/instructionDecoder.sv
hdl/fetchDecodeStage.sv
bench/fetchDecodeStage_sva.sv
bench/fetchDecodeStageTb.sv
